/* ros2_ether_bridge.f */
logic/ros2_ether_pkg.sv
logic/byte_queue.sv
logic/app_data_arbiter.sv
logic/buffer_handoff.sv
logic/ros2_ether_bridge.sv
tests/ros2_ether_bridge_properties.sv
tests/tb_ros2_ether_bridge.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build_verilator
LOG_FILE=sim.log
TOP=tb_ros2_ether_bridge

verilator --binary --timing --assert \
  --top-module "$TOP" \
  -Mdir "$BUILD_DIR" \
  -f ros2_ether_bridge.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "TEST RESULT: PASS" "$LOG_FILE"; then
  exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1

/* tests/tb_ros2_ether_bridge.sv */
`timescale 1ns/10ps

module tb_ros2_ether_bridge;

  // ********************************************************
  // Run length
  // ********************************************************

  localparam int unsigned RESET_CYCLES = 5;
  localparam int unsigned RAND_BLOCK   = 900;  // Cycles per random stimulus block
  localparam int unsigned FLOOD_CYCLES = ros2_ether_pkg::RX_QUEUE_DEPTH + 4;
  localparam int unsigned ENABLE_HOLD  = 20;
  localparam int unsigned STIM_CYCLES  = RESET_CYCLES + 1 + 3 * RAND_BLOCK
                                       + 3 * FLOOD_CYCLES + 2 * ENABLE_HOLD;
  localparam int unsigned TIMEOUT_CYCLES = (STIM_CYCLES * 7) / 4;

  logic clk;
  logic rst_n;
  logic ether_en;

  ros2_ether_pkg::net_cfg_t    net_cfg_in;
  ros2_ether_pkg::net_cfg_t    net_cfg_out;
  ros2_ether_pkg::owner_req_t  core_app;
  ros2_ether_pkg::owner_req_t  cpu_app;
  ros2_ether_pkg::grant_pair_t app_grant;
  logic [ros2_ether_pkg::BUF_COUNT-1:0] core_buf_rel;
  logic [ros2_ether_pkg::BUF_COUNT-1:0] cpu_buf_rel;
  ros2_ether_pkg::grant_pair_t [ros2_ether_pkg::BUF_COUNT-1:0] buf_grant;

  logic       tx_wr_en;
  logic [7:0] tx_din;
  logic       tx_full;
  logic       tx_rd_en;
  logic [7:0] tx_dout;
  logic       tx_empty;
  logic       rx_wr_en;
  logic [7:0] rx_din;
  logic       rx_full;
  logic       rx_rd_en;
  logic [7:0] rx_dout;
  logic       rx_empty;

  // Reference model state
  logic [7:0] tx_model[$];
  logic [7:0] rx_model[$];
  ros2_ether_pkg::app_owner_e app_model;
  logic [ros2_ether_pkg::BUF_COUNT-1:0] buf_cpu_model;  // High where the CPU owns the buffer

  logic [31:0] lcg_state;
  int unsigned cycle_count = 0;

  ros2_ether_bridge dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_ether_en     (ether_en),
    .i_net_cfg      (net_cfg_in),
    .o_net_cfg      (net_cfg_out),
    .i_core_app     (core_app),
    .i_cpu_app      (cpu_app),
    .o_app_grant    (app_grant),
    .i_core_buf_rel (core_buf_rel),
    .i_cpu_buf_rel  (cpu_buf_rel),
    .o_buf_grant    (buf_grant),
    .i_tx_wr_en     (tx_wr_en),
    .i_tx_din       (tx_din),
    .o_tx_full      (tx_full),
    .i_tx_rd_en     (tx_rd_en),
    .o_tx_dout      (tx_dout),
    .o_tx_empty     (tx_empty),
    .i_rx_wr_en     (rx_wr_en),
    .i_rx_din       (rx_din),
    .o_rx_full      (rx_full),
    .i_rx_rd_en     (rx_rd_en),
    .o_rx_dout      (rx_dout),
    .o_rx_empty     (rx_empty)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Simulation stopped by the cycle limit");
    end
  end

  // ********************************************************
  // Random numbers and the byte-order rule
  // ********************************************************

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // True with a probability of odds out of four
  function automatic logic chance_in_four(input logic [2:0] odds);
    logic [31:0] r;
    r = next_rand();
    return {1'b0, r[17:16]} < odds;
  endfunction

  function automatic logic [7:0] random_byte();
    logic [31:0] r;
    r = next_rand();
    return r[23:16];
  endfunction

  function automatic ros2_ether_pkg::net_cfg_t random_cfg();
    logic [159:0] bits;
    bits = {next_rand(), next_rand(), next_rand(), next_rand(), next_rand()};
    return bits[143:0];
  endfunction

  // Low byte of the input ends up as the high byte of an nbytes-wide result
  function automatic logic [47:0] reverse_bytes(input logic [47:0] value,
                                                input int unsigned nbytes);
    logic [47:0] result;
    logic [47:0] rest;
    result = '0;
    rest   = value;
    for (int unsigned i = 0; i < nbytes; i++) begin
      result = {result[39:0], rest[7:0]};
      rest   = rest >> 8;
    end
    return result;
  endfunction

  function automatic ros2_ether_pkg::net_cfg_t expected_cfg(
    input ros2_ether_pkg::net_cfg_t cfg, input logic en);
    ros2_ether_pkg::net_cfg_t exp_cfg;
    logic [47:0] tmp;
    exp_cfg = '0;
    if (en) begin
      exp_cfg.mac     = reverse_bytes(cfg.mac, 6);
      tmp             = reverse_bytes({16'h0000, cfg.ip}, 4);
      exp_cfg.ip      = tmp[31:0];
      tmp             = reverse_bytes({16'h0000, cfg.gateway}, 4);
      exp_cfg.gateway = tmp[31:0];
      tmp             = reverse_bytes({16'h0000, cfg.mask}, 4);
      exp_cfg.mask    = tmp[31:0];
    end
    return exp_cfg;
  endfunction

  // ********************************************************
  // Checking and model
  // ********************************************************

  task automatic check_value(input string name, input logic [143:0] actual,
                             input logic [143:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  task automatic check_outputs();
    logic [1:0] app_exp;
    logic [2*ros2_ether_pkg::BUF_COUNT-1:0] buf_exp;
    ros2_ether_pkg::net_cfg_t cfg_exp;
    cfg_exp = expected_cfg(net_cfg_in, ether_en);
    app_exp = {ether_en && (app_model == ros2_ether_pkg::APP_OWNER_CORE),
               ether_en && (app_model == ros2_ether_pkg::APP_OWNER_CPU)};
    for (int g = 0; g < int'(ros2_ether_pkg::BUF_COUNT); g++) begin
      buf_exp[2*g+1] = ether_en & ~buf_cpu_model[g];  // Core bit sits above the CPU bit
      buf_exp[2*g]   = ether_en &  buf_cpu_model[g];
    end
    check_value("o_net_cfg", 144'(net_cfg_out), 144'(cfg_exp));
    check_value("o_app_grant", 144'(app_grant), 144'(app_exp));
    check_value("o_buf_grant", 144'(buf_grant), 144'(buf_exp));
    check_value("o_tx_empty", 144'(tx_empty), 144'(tx_model.size() == 0));
    check_value("o_tx_full", 144'(tx_full),
                144'(tx_model.size() == int'(ros2_ether_pkg::TX_QUEUE_DEPTH)));
    if (tx_model.size() != 0) begin
      check_value("o_tx_dout", 144'(tx_dout), 144'(tx_model[0]));
    end
    check_value("o_rx_empty", 144'(rx_empty), 144'(rx_model.size() == 0));
    check_value("o_rx_full", 144'(rx_full),
                144'(rx_model.size() == int'(ros2_ether_pkg::RX_QUEUE_DEPTH)));
    if (rx_model.size() != 0) begin
      check_value("o_rx_dout", 144'(rx_dout), 144'(rx_model[0]));
    end
  endtask

  // Applies the inputs of this cycle as the next rising edge will
  task automatic update_model();
    logic tx_push;
    logic tx_pop;
    logic rx_push;
    logic rx_pop;
    tx_push = tx_wr_en && (tx_model.size() < int'(ros2_ether_pkg::TX_QUEUE_DEPTH));
    tx_pop  = tx_rd_en && (tx_model.size() > 0);
    rx_push = rx_wr_en && (rx_model.size() < int'(ros2_ether_pkg::RX_QUEUE_DEPTH));
    rx_pop  = rx_rd_en && (rx_model.size() > 0);
    if (tx_pop) void'(tx_model.pop_front());
    if (tx_push) tx_model.push_back(tx_din);
    if (rx_pop) void'(rx_model.pop_front());
    if (rx_push) rx_model.push_back(rx_din);

    if (app_model == ros2_ether_pkg::APP_OWNER_NONE) begin
      if (core_app.req) app_model = ros2_ether_pkg::APP_OWNER_CORE;
      else if (cpu_app.req) app_model = ros2_ether_pkg::APP_OWNER_CPU;
    end else if (app_model == ros2_ether_pkg::APP_OWNER_CORE && core_app.rel) begin
      app_model = ros2_ether_pkg::APP_OWNER_NONE;
    end else if (app_model == ros2_ether_pkg::APP_OWNER_CPU && cpu_app.rel) begin
      app_model = ros2_ether_pkg::APP_OWNER_NONE;
    end

    // Only the current owner's release flips a buffer
    for (int g = 0; g < int'(ros2_ether_pkg::BUF_COUNT); g++) begin
      if (buf_cpu_model[g] ? cpu_buf_rel[g] : core_buf_rel[g]) begin
        buf_cpu_model[g] = ~buf_cpu_model[g];
      end
    end
  endtask

  task automatic settle_and_check();
    #2;
    check_outputs();
    update_model();
  endtask

  // ********************************************************
  // Stimulus
  // ********************************************************

  task automatic hold_quiet();
    ether_en     = 1'b1;
    core_app     = '0;
    cpu_app      = '0;
    core_buf_rel = '0;
    cpu_buf_rel  = '0;
    tx_wr_en     = 1'b0;
    tx_rd_en     = 1'b0;
    rx_wr_en     = 1'b0;
    rx_rd_en     = 1'b0;
  endtask

  task automatic randomize_inputs(input logic [2:0] wr_odds, input logic [2:0] rd_odds);
    ether_en     = chance_in_four(3'd3);
    net_cfg_in   = random_cfg();
    core_app.req = chance_in_four(3'd2);
    core_app.rel = chance_in_four(3'd1);
    cpu_app.req  = chance_in_four(3'd2);
    cpu_app.rel  = chance_in_four(3'd1);
    for (int g = 0; g < int'(ros2_ether_pkg::BUF_COUNT); g++) begin
      core_buf_rel[g] = chance_in_four(3'd1);
      cpu_buf_rel[g]  = chance_in_four(3'd1);
    end
    tx_wr_en = chance_in_four(wr_odds);
    tx_din   = random_byte();
    tx_rd_en = chance_in_four(rd_odds);
    rx_wr_en = chance_in_four(wr_odds);
    rx_din   = random_byte();
    rx_rd_en = chance_in_four(rd_odds);
  endtask

  task automatic run_random(input logic [2:0] wr_odds, input logic [2:0] rd_odds);
    repeat (RAND_BLOCK) begin
      @(negedge clk);
      randomize_inputs(wr_odds, rd_odds);
      settle_and_check();
    end
  endtask

  task automatic drain_queues();
    repeat (FLOOD_CYCLES) begin
      @(negedge clk);
      hold_quiet();
      tx_rd_en = 1'b1;
      rx_rd_en = 1'b1;
      settle_and_check();
    end
  endtask

  task automatic flood_queues();
    repeat (FLOOD_CYCLES) begin
      @(negedge clk);
      hold_quiet();
      tx_wr_en = 1'b1;
      tx_din   = random_byte();
      rx_wr_en = 1'b1;
      rx_din   = random_byte();
      settle_and_check();
    end
  endtask

  initial begin
    lcg_state     = 32'd10;
    clk           = 1'b0;
    rst_n         = 1'b0;
    net_cfg_in    = '0;
    tx_din        = '0;
    rx_din        = '0;
    hold_quiet();
    app_model     = ros2_ether_pkg::APP_OWNER_NONE;
    buf_cpu_model = 2'b10;  // Receive buffer with the core, transmit buffer with the CPU

    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    @(negedge clk);
    hold_quiet();
    net_cfg_in = random_cfg();
    #2;
    check_value("o_buf_grant", 144'(buf_grant), 144'(4'b0110));
    check_outputs();
    update_model();

    run_random(3'd3, 3'd1);  // Write heavy, reaches full
    run_random(3'd1, 3'd3);  // Read heavy, reaches empty
    run_random(3'd2, 3'd2);

    drain_queues();
    flood_queues();
    drain_queues();

    repeat (ENABLE_HOLD) begin
      @(negedge clk);
      hold_quiet();
      ether_en   = 1'b0;
      net_cfg_in = random_cfg();
      settle_and_check();
    end
    repeat (ENABLE_HOLD) begin
      @(negedge clk);
      hold_quiet();
      net_cfg_in = random_cfg();
      settle_and_check();
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* tests/ros2_ether_bridge_properties.sv */
`timescale 1ns/10ps

module ros2_ether_bridge_properties (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   i_ether_en,
  input  logic                                   i_tx_full,
  input  logic                                   i_tx_empty,
  input  logic                                   i_rx_full,
  input  logic                                   i_rx_empty,
  input  ros2_ether_pkg::grant_pair_t            i_app_grant,
  input  ros2_ether_pkg::grant_pair_t [ros2_ether_pkg::BUF_COUNT-1:0] i_buf_grant
);

  // ********************************************************
  // Queue flags
  // ********************************************************

  tx_flags_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n) !(i_tx_full && i_tx_empty)
  ) else $error("Outgoing queue shows full and empty together");

  rx_flags_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n) !(i_rx_full && i_rx_empty)
  ) else $error("Incoming queue shows full and empty together");

  // ********************************************************
  // Grants
  // ********************************************************

  app_grant_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n) !(i_app_grant.core && i_app_grant.cpu)
  ) else $error("Application data granted to core and CPU at once");

  app_grant_needs_enable: assert property (
    @(posedge clk) disable iff (!rst_n) !i_ether_en |-> (i_app_grant == '0)
  ) else $error("Application data grant while Ethernet is off");

  buf_grant_needs_enable: assert property (
    @(posedge clk) disable iff (!rst_n) !i_ether_en |-> (i_buf_grant == '0)
  ) else $error("Buffer grant while Ethernet is off");

endmodule

bind ros2_ether_bridge ros2_ether_bridge_properties props_i (
  .clk         (clk),
  .rst_n       (rst_n),
  .i_ether_en  (i_ether_en),
  .i_tx_full   (o_tx_full),
  .i_tx_empty  (o_tx_empty),
  .i_rx_full   (o_rx_full),
  .i_rx_empty  (o_rx_empty),
  .i_app_grant (o_app_grant),
  .i_buf_grant (o_buf_grant)
);

/* logic/ros2_ether_bridge.sv */
`timescale 1ns/10ps

module ros2_ether_bridge (
  input  logic                                   clk,
  input  logic                                   rst_n,

  input  logic                                   i_ether_en,

  // Network settings
  input  ros2_ether_pkg::net_cfg_t               i_net_cfg,
  output ros2_ether_pkg::net_cfg_t               o_net_cfg,

  // Application-data block sharing
  input  ros2_ether_pkg::owner_req_t             i_core_app,
  input  ros2_ether_pkg::owner_req_t             i_cpu_app,
  output ros2_ether_pkg::grant_pair_t            o_app_grant,

  // UDP buffer handoff, index 0 receive and index 1 transmit
  input  logic [ros2_ether_pkg::BUF_COUNT-1:0]   i_core_buf_rel,
  input  logic [ros2_ether_pkg::BUF_COUNT-1:0]   i_cpu_buf_rel,
  output ros2_ether_pkg::grant_pair_t [ros2_ether_pkg::BUF_COUNT-1:0] o_buf_grant,

  // Outgoing payload stream
  input  logic                                   i_tx_wr_en,
  input  logic [7:0]                             i_tx_din,
  output logic                                   o_tx_full,
  input  logic                                   i_tx_rd_en,
  output logic [7:0]                             o_tx_dout,
  output logic                                   o_tx_empty,

  // Incoming payload stream
  input  logic                                   i_rx_wr_en,
  input  logic [7:0]                             i_rx_din,
  output logic                                   o_rx_full,
  input  logic                                   i_rx_rd_en,
  output logic [7:0]                             o_rx_dout,
  output logic                                   o_rx_empty
);

  // ********************************************************
  // Payload queues
  // ********************************************************

  byte_queue #(
    .DEPTH (ros2_ether_pkg::TX_QUEUE_DEPTH)
  ) tx_queue_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_wr_en (i_tx_wr_en),
    .i_din   (i_tx_din),
    .o_full  (o_tx_full),
    .i_rd_en (i_tx_rd_en),
    .o_dout  (o_tx_dout),
    .o_empty (o_tx_empty)
  );

  byte_queue #(
    .DEPTH (ros2_ether_pkg::RX_QUEUE_DEPTH)
  ) rx_queue_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_wr_en (i_rx_wr_en),
    .i_din   (i_rx_din),
    .o_full  (o_rx_full),
    .i_rd_en (i_rx_rd_en),
    .o_dout  (o_rx_dout),
    .o_empty (o_rx_empty)
  );

  // ********************************************************
  // Ownership of shared blocks
  // ********************************************************

  app_data_arbiter app_arbiter_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_enable (i_ether_en),
    .i_core   (i_core_app),
    .i_cpu    (i_cpu_app),
    .o_grant  (o_app_grant)
  );

  buffer_handoff buf_handoff_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_enable   (i_ether_en),
    .i_core_rel (i_core_buf_rel),
    .i_cpu_rel  (i_cpu_buf_rel),
    .o_grant    (o_buf_grant)
  );

  // ********************************************************
  // Network settings
  // ********************************************************

  // Stack sees all zeros while Ethernet is off
  assign o_net_cfg = ros2_ether_pkg::to_network_order(i_net_cfg)
                   & {$bits(ros2_ether_pkg::net_cfg_t){i_ether_en}};

endmodule

/* logic/buffer_handoff.sv */
`timescale 1ns/10ps

module buffer_handoff (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   i_enable,

  // One release pulse per buffer from each side
  input  logic [ros2_ether_pkg::BUF_COUNT-1:0]   i_core_rel,
  input  logic [ros2_ether_pkg::BUF_COUNT-1:0]   i_cpu_rel,

  output ros2_ether_pkg::grant_pair_t [ros2_ether_pkg::BUF_COUNT-1:0] o_grant
);

  // ********************************************************
  // One ownership toggle per buffer
  // ********************************************************

  for (genvar g = 0; g < ros2_ether_pkg::BUF_COUNT; g++) begin : g_buf

    // Low while the core holds the buffer, high while the CPU does
    logic cpu_owns;

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        cpu_owns <= ros2_ether_pkg::BUF_RESET_OWNER[g];
      end else if (!cpu_owns && i_core_rel[g]) begin
        cpu_owns <= 1'b1;  // Core hands over
      end else if (cpu_owns && i_cpu_rel[g]) begin
        cpu_owns <= 1'b0;  // CPU hands back
      end
    end

    // A release from the side without the buffer falls through both tests above

    assign o_grant[g].core = i_enable & ~cpu_owns;
    assign o_grant[g].cpu  = i_enable &  cpu_owns;

  end

endmodule

/* logic/app_data_arbiter.sv */
`timescale 1ns/10ps

module app_data_arbiter (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       i_enable,
  input  ros2_ether_pkg::owner_req_t i_core,
  input  ros2_ether_pkg::owner_req_t i_cpu,
  output ros2_ether_pkg::grant_pair_t o_grant
);

  ros2_ether_pkg::app_owner_e owner;

  // ********************************************************
  // Owner state
  // ********************************************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      owner <= ros2_ether_pkg::APP_OWNER_NONE;
    end else begin
      case (owner)
        ros2_ether_pkg::APP_OWNER_NONE: begin
          if (i_core.req) begin
            owner <= ros2_ether_pkg::APP_OWNER_CORE;  // Core wins a tie
          end else if (i_cpu.req) begin
            owner <= ros2_ether_pkg::APP_OWNER_CPU;
          end
        end
        ros2_ether_pkg::APP_OWNER_CORE: begin
          if (i_core.rel) begin
            owner <= ros2_ether_pkg::APP_OWNER_NONE;
          end
        end
        ros2_ether_pkg::APP_OWNER_CPU: begin
          if (i_cpu.rel) begin
            owner <= ros2_ether_pkg::APP_OWNER_NONE;
          end
        end
        default: owner <= ros2_ether_pkg::APP_OWNER_NONE;
      endcase
    end
  end

  // The enable hides the grant but leaves the owner in place
  assign o_grant.core = i_enable & (owner == ros2_ether_pkg::APP_OWNER_CORE);
  assign o_grant.cpu  = i_enable & (owner == ros2_ether_pkg::APP_OWNER_CPU);

endmodule

/* logic/byte_queue.sv */
`timescale 1ns/10ps

module byte_queue #(
  parameter int unsigned DEPTH = 16
) (
  input  logic       clk,
  input  logic       rst_n,

  input  logic       i_wr_en,
  input  logic [7:0] i_din,
  output logic       o_full,

  input  logic       i_rd_en,
  output logic [7:0] o_dout,
  output logic       o_empty
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [7:0]       mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_wr;
  logic             do_rd;

  // Strobes that hit a full or empty queue are dropped here
  assign do_wr = i_wr_en & ~o_full;
  assign do_rd = i_rd_en & ~o_empty;

  assign o_full  = (count == CNT_W'(DEPTH));
  assign o_empty = (count == '0);

  // Show-ahead: the oldest entry is always on the output
  assign o_dout = mem[rd_ptr];

  // ********************************************************
  // Storage
  // ********************************************************

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= i_din;
    end
  end

  // ********************************************************
  // Pointers and occupancy
  // ********************************************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (do_wr) begin
      if (wr_ptr == PTR_W'(DEPTH - 1)) begin
        wr_ptr <= '0;  // Wrap for any depth, not only powers of two
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
    end else if (do_rd) begin
      if (rd_ptr == PTR_W'(DEPTH - 1)) begin
        rd_ptr <= '0;
      end else begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Push and pop together leave it unchanged
      endcase
    end
  end

endmodule

/* logic/ros2_ether_pkg.sv */
package ros2_ether_pkg;

  // ********************************************************
  // Sizes and reset values
  // ********************************************************

  localparam int unsigned TX_QUEUE_DEPTH = 16;  // Outgoing payload bytes
  localparam int unsigned RX_QUEUE_DEPTH = 32;  // Incoming payload bytes

  // Index 0 is the UDP receive buffer, index 1 the UDP transmit buffer
  localparam int unsigned BUF_COUNT = 2;

  // Owner after reset per buffer, 0 for the core and 1 for the CPU
  localparam logic [BUF_COUNT-1:0] BUF_RESET_OWNER = 2'b10;

  // ********************************************************
  // Types
  // ********************************************************

  typedef enum logic [1:0] {
    APP_OWNER_NONE = 2'b00,
    APP_OWNER_CORE = 2'b01,
    APP_OWNER_CPU  = 2'b10
  } app_owner_e;

  typedef struct packed {
    logic req;  // Request strobe
    logic rel;  // Release strobe
  } owner_req_t;

  typedef struct packed {
    logic core;
    logic cpu;
  } grant_pair_t;

  // Host order as written by the CPU
  typedef struct packed {
    logic [47:0] mac;
    logic [31:0] ip;
    logic [31:0] gateway;
    logic [31:0] mask;
  } net_cfg_t;

  // Swaps the bytes of every field so the first byte on the wire is the low one
  function automatic net_cfg_t to_network_order(input net_cfg_t cfg);
    net_cfg_t swapped;
    for (int b = 0; b < 6; b++) begin
      swapped.mac[8*b +: 8] = cfg.mac[8*(5-b) +: 8];
    end
    for (int b = 0; b < 4; b++) begin
      swapped.ip[8*b +: 8]      = cfg.ip[8*(3-b) +: 8];
      swapped.gateway[8*b +: 8] = cfg.gateway[8*(3-b) +: 8];
      swapped.mask[8*b +: 8]    = cfg.mask[8*(3-b) +: 8];
    end
    return swapped;
  endfunction

endpackage
